// File: sources.f
src/dcachePkg.sv
src/dcacheReqPort.sv
src/dcacheCtrl.sv
src/dcacheTagStore.sv
src/dcacheDataStore.sv
src/dcacheBusPort.sv
src/dcacheTop.sv
tb/dcacheTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcacheTb
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -o $(TOP) -f sources.f
	@out="$$(./$(MDIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)

// File: tb/dcacheTb.sv
`timescale 1ns/10ps
`default_nettype none

module dcacheTb;

  localparam int waitLimit = 400;

  logic                 clk           = 1'b0;
  logic                 rst_n         = 1'b0;
  logic                 reqValid_i    = 1'b0;
  logic                 reqWrite_i    = 1'b0;
  dcachePkg::addrT      reqAddr_i     = '0;
  dcachePkg::wordT      reqWrData_i   = '0;
  dcachePkg::byteMaskT  reqWrMask_i   = '0;
  logic                 rdReqReady_i  = 1'b0;
  logic                 rdDataValid_i = 1'b0;
  dcachePkg::wordT      rdData_i      = '0;
  logic                 rdLast_i      = 1'b0;
  logic                 wrReqReady_i  = 1'b0;
  logic                 reqReady_o;
  logic                 respValid_o;
  dcachePkg::wordT      respData_o;
  logic                 rdReqValid_o;
  dcachePkg::addrT      rdAddr_o;
  logic                 wrReqValid_o;
  dcachePkg::addrT      wrAddr_o;
  dcachePkg::lineT      wrData_o;

  // memory behind the bus and the architectural value of every word
  dcachePkg::wordT  mem   [256];
  dcachePkg::wordT  model [256];

  logic [31:0]  stimSeed   = 32'h6960684b;
  logic [31:0]  busSeed    = 32'h6960684b ^ 32'h3c3c5a5a;
  string        curTest    = "reset";
  int           errors     = 0;
  int           checks     = 0;
  int           busErrors  = 0;
  int           busChecks  = 0;
  int           testsRun   = 0;
  int           testsFailed = 0;
  int           testStartErrs = 0;
  bit           timedOut   = 1'b0;
  logic         stallBus   = 1'b0;

  // responder state
  int           beatsLeft  = 0;
  logic [1:0]   beatIdx    = 2'd0;
  logic [5:0]   rdBase     = 6'd0;
  logic         rdHeld     = 1'b0;
  logic         wrHeld     = 1'b0;
  dcachePkg::addrT rdHeldAddr = '0;
  dcachePkg::addrT wrHeldAddr = '0;
  logic [7:0]   wbIdx;
  logic [15:0]  busR;
  int           wbCount    = 0;
  int           rdCount    = 0;

  dcacheTop dcacheTop_i (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] lcgStep(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // low LCG bits repeat quickly so only the upper half is used
  function automatic logic [15:0] stimRand();
    stimSeed = lcgStep(stimSeed);
    return stimSeed[31:16];
  endfunction

  function automatic logic [15:0] busRand();
    busSeed = lcgStep(busSeed);
    return busSeed[31:16];
  endfunction

  function automatic dcachePkg::wordT fillWord(input logic [31:0] a);
    return {a * 32'h9e3779b1, a ^ 32'h5a5ac3c3};
  endfunction

  function automatic dcachePkg::wordT mergeBytes(input dcachePkg::wordT old,
      input dcachePkg::wordT data, input dcachePkg::byteMaskT mask);
    dcachePkg::wordT res;
    res = old;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) begin
        res[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // three tags per set overflow its two ways
  function automatic dcachePkg::addrT randomAddr();
    logic [15:0] r;
    logic [1:0]  tagSel;
    r = stimRand();
    tagSel = r[15:14];
    if (tagSel == 2'd3) begin
      tagSel = r[13] ? 2'd1 : 2'd2;
    end
    return {21'd0, tagSel, r[12:9], r[8:7], r[6:4]};
  endfunction

  task automatic checkValue(input string what, input dcachePkg::wordT exp,
      input dcachePkg::wordT act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED %s: %s expected %h, actual %h", curTest, what, exp, act);
      errors++;
    end
  endtask

  task automatic checkTrue(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      $display("ERROR %s: %s", curTest, msg);
      errors++;
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("ERROR %s: timed out waiting for %s", curTest, what);
    errors++;
    timedOut = 1'b1;
  endtask

  // one request from offer to response starting at a rising edge
  task automatic doRequest(input logic wr, input dcachePkg::addrT addr,
      input dcachePkg::wordT data, input dcachePkg::byteMaskT mask,
      output dcachePkg::wordT rdata, output int latency);
    int  t;
    bit  accepted;
    bit  responded;
    rdata = '0;
    latency = 0;
    accepted = 1'b0;
    responded = 1'b0;
    t = 0;
    if (timedOut) begin
      return;
    end
    reqValid_i  <= 1'b1;
    reqWrite_i  <= wr;
    reqAddr_i   <= addr;
    reqWrData_i <= data;
    reqWrMask_i <= mask;
    while (!accepted && !timedOut) begin
      @(posedge clk);
      checkTrue(!respValid_o, "response seen with no request outstanding");
      if (reqReady_o) begin
        accepted = 1'b1;
      end else begin
        t++;
        if (t > waitLimit) begin
          reportTimeout("request acceptance");
        end
      end
    end
    reqValid_i <= 1'b0;
    while (accepted && !responded && !timedOut) begin
      @(posedge clk);
      latency++;
      if (respValid_o) begin
        responded = 1'b1;
        rdata = respData_o;
      end else if (latency > waitLimit) begin
        reportTimeout("response");
      end
    end
    if (wr && responded) begin
      model[addr[10:3]] = mergeBytes(model[addr[10:3]], data, mask);
    end
  endtask

  task automatic randomOp();
    logic [15:0]          r;
    dcachePkg::addrT      addr;
    dcachePkg::wordT      data;
    dcachePkg::wordT      rdata;
    int                   latency;
    r = stimRand();
    addr = randomAddr();
    data = {stimRand(), stimRand(), stimRand(), stimRand()};
    doRequest(r[15], addr, data, r[7:0], rdata, latency);
    if (!r[15] && !timedOut) begin
      checkValue("load data", model[addr[10:3]], rdata);
    end
  endtask

  task automatic startTest(input string name);
    curTest = name;
    testStartErrs = errors + busErrors;
    testsRun++;
  endtask

  task automatic endTest();
    if (errors + busErrors == testStartErrs) begin
      $display("%-14s PASS", curTest);
    end else begin
      $display("%-14s FAIL (%0d errors)", curTest, errors + busErrors - testStartErrs);
      testsFailed++;
    end
  endtask

  // bus responder sampling DUT outputs as they were before the edge
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 256; i++) begin
        mem[i] = fillWord(32'(i) << 3);
      end
      beatsLeft = 0;
      rdHeld = 1'b0;
      wrHeld = 1'b0;
      rdDataValid_i <= 1'b0;
      rdLast_i      <= 1'b0;
      rdReqReady_i  <= 1'b0;
      wrReqReady_i  <= 1'b0;
    end else begin
      busChecks++;
      assert (!((rdReqValid_o || wrReqValid_o) && reqReady_o)) else begin
        $display("ERROR %s: reqReady_o high while a bus request is pending", curTest);
        busErrors++;
      end
      if (rdHeld) begin
        busChecks++;
        assert (rdReqValid_o) else begin
          $display("ERROR %s: rdReqValid_o dropped before the handshake", curTest);
          busErrors++;
        end
        busChecks++;
        assert (rdAddr_o === rdHeldAddr) else begin
          $display("FAILED %s: held rdAddr_o expected %h, actual %h", curTest,
                   rdHeldAddr, rdAddr_o);
          busErrors++;
        end
      end
      if (wrHeld) begin
        busChecks++;
        assert (wrReqValid_o) else begin
          $display("ERROR %s: wrReqValid_o dropped before the handshake", curTest);
          busErrors++;
        end
        busChecks++;
        assert (wrAddr_o === wrHeldAddr) else begin
          $display("FAILED %s: held wrAddr_o expected %h, actual %h", curTest,
                   wrHeldAddr, wrAddr_o);
          busErrors++;
        end
      end
      rdHeld = rdReqValid_o && !rdReqReady_i;
      rdHeldAddr = rdAddr_o;
      wrHeld = wrReqValid_o && !wrReqReady_i;
      wrHeldAddr = wrAddr_o;
      if (rdReqValid_o && rdReqReady_i) begin
        busChecks++;
        assert (rdAddr_o[4:0] == 5'd0) else begin
          $display("ERROR %s: read address %h is not line aligned", curTest, rdAddr_o);
          busErrors++;
        end
        rdBase = rdAddr_o[10:5];
        beatIdx = 2'd0;
        beatsLeft = 4;
        rdCount++;
      end
      if (wrReqValid_o && wrReqReady_i) begin
        busChecks++;
        assert (wrAddr_o[4:0] == 5'd0) else begin
          $display("ERROR %s: write address %h is not line aligned", curTest, wrAddr_o);
          busErrors++;
        end
        for (int w = 0; w < 4; w++) begin
          wbIdx = {wrAddr_o[10:5], 2'(w)};
          busChecks++;
          assert (wrData_o[w*dcachePkg::xlen +: dcachePkg::xlen] === model[wbIdx]) else begin
            $display("FAILED %s: write-back word %h expected %h, actual %h", curTest,
                     wbIdx, model[wbIdx], wrData_o[w*dcachePkg::xlen +: dcachePkg::xlen]);
            busErrors++;
          end
          mem[wbIdx] = wrData_o[w*dcachePkg::xlen +: dcachePkg::xlen];
        end
        wbCount++;
      end
      busR = busRand();
      // a beat now and then is held back to open a gap
      if (beatsLeft != 0 && busR[5:4] != 2'd0) begin
        rdDataValid_i <= 1'b1;
        rdData_i      <= mem[{rdBase, beatIdx}];
        rdLast_i      <= (beatsLeft == 1);
        beatIdx = beatIdx + 2'd1;
        beatsLeft = beatsLeft - 1;
      end else begin
        rdDataValid_i <= 1'b0;
        rdLast_i      <= 1'b0;
      end
      rdReqReady_i <= !stallBus || (busR[1:0] == 2'd0);
      wrReqReady_i <= !stallBus || (busR[3:2] == 2'd0);
    end
  end

  initial begin
    dcachePkg::addrT  addr;
    dcachePkg::wordT  data;
    dcachePkg::wordT  expected;
    dcachePkg::wordT  rdata;
    logic [15:0]      r;
    int               latency;
    int               wb0;
    int               rd0;
    for (int i = 0; i < 256; i++) begin
      model[i] = fillWord(32'(i) << 3);
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    startTest("reset");
    checkValue("reqReady_o", 64'd1, 64'(reqReady_o));
    checkValue("respValid_o", 64'd0, 64'(respValid_o));
    checkValue("rdReqValid_o", 64'd0, 64'(rdReqValid_o));
    checkValue("wrReqValid_o", 64'd0, 64'(wrReqValid_o));
    endTest();

    startTest("loads");
    for (int k = 0; k < 40; k++) begin
      addr = randomAddr();
      doRequest(1'b0, addr, '0, '0, rdata, latency);
      if (!timedOut) begin
        checkValue("load data", model[addr[10:3]], rdata);
      end
    end
    endTest();

    startTest("stores");
    for (int k = 0; k < 30; k++) begin
      r = stimRand();
      addr = randomAddr();
      data = {stimRand(), stimRand(), stimRand(), stimRand()};
      expected = mergeBytes(model[addr[10:3]], data, r[7:0]);
      doRequest(1'b1, addr, data, r[7:0], rdata, latency);
      doRequest(1'b0, addr, '0, '0, rdata, latency);
      if (!timedOut) begin
        checkValue("load after store", expected, rdata);
      end
    end
    endTest();

    startTest("evictions");
    wb0 = wbCount;
    rd0 = rdCount;
    for (int k = 0; k < 150; k++) begin
      randomOp();
    end
    checkTrue(wbCount > wb0, "no dirty line was written back");
    checkTrue(rdCount > rd0, "no line was refilled");
    endTest();

    startTest("hit latency");
    for (int k = 0; k < 8; k++) begin
      addr = randomAddr();
      doRequest(1'b0, addr, '0, '0, rdata, latency);
      doRequest(1'b0, addr, '0, '0, rdata, latency);
      if (!timedOut) begin
        checkValue("hit latency", 64'd1, 64'(latency));
        checkValue("repeated load data", model[addr[10:3]], rdata);
      end
    end
    endTest();

    startTest("backpressure");
    stallBus <= 1'b1;
    for (int k = 0; k < 60; k++) begin
      randomOp();
    end
    stallBus <= 1'b0;
    endTest();

    $display("tests: %0d, failed: %0d, checks: %0d, errors: %0d", testsRun, testsFailed,
             checks + busChecks, errors + busErrors);
    if (errors + busErrors == 0 && !timedOut) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/dcacheTop.sv
`timescale 1ns/10ps
`default_nettype none

module dcacheTop (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  reqValid_i,
  input  wire                  reqWrite_i,
  input  dcachePkg::addrT      reqAddr_i,
  input  dcachePkg::wordT      reqWrData_i,
  input  dcachePkg::byteMaskT  reqWrMask_i,
  output logic                 reqReady_o,
  output logic                 respValid_o,
  output dcachePkg::wordT      respData_o,
  output logic                 rdReqValid_o,
  output dcachePkg::addrT      rdAddr_o,
  input  wire                  rdReqReady_i,
  input  wire                  rdDataValid_i,
  input  dcachePkg::wordT      rdData_i,
  input  wire                  rdLast_i,
  output logic                 wrReqValid_o,
  output dcachePkg::addrT      wrAddr_o,
  output dcachePkg::lineT      wrData_o,
  input  wire                  wrReqReady_i
);

  logic latchEn, lookupEn, storeHit, installEn;
  logic wbStart, rdStart, refillEn, rdDone, wbDone;
  logic reqWrite, hit, hitWay, dirtyVictim, victimWay;
  dcachePkg::tagT      reqTag;
  dcachePkg::tagT      victimTag;
  dcachePkg::indexT    reqIndex;
  dcachePkg::wordSelT  reqWordSel;
  dcachePkg::wordT     storeData;
  dcachePkg::wordT     storeBitMask;
  dcachePkg::lineT     victimLine;
  dcachePkg::lineT     refillLine;

  dcacheReqPort reqPort_i (
    .clk, .rst_n, .latchEn, .lookupEn, .reqWrite_i, .reqAddr_i, .reqWrData_i,
    .reqWrMask_i, .reqWrite, .reqTag, .reqIndex, .reqWordSel, .storeData, .storeBitMask
  );

  dcacheCtrl ctrl_i (
    .clk, .rst_n, .reqValid_i, .reqWrite, .hit, .dirtyVictim, .rdDone, .wbDone,
    .reqReady_o, .respValid_o, .latchEn, .lookupEn, .storeHit, .installEn,
    .wbStart, .rdStart, .refillEn
  );

  dcacheTagStore tagStore_i (
    .clk, .rst_n, .reqTag, .reqIndex, .lookupEn, .storeHit, .installEn,
    .hit, .hitWay, .dirtyVictim, .victimWay, .victimTag
  );

  dcacheDataStore dataStore_i (
    .clk, .rst_n, .reqIndex, .reqWordSel, .storeData, .storeBitMask, .storeHit,
    .hitWay, .installEn, .victimWay, .refillLine, .respData_o, .victimLine
  );

  dcacheBusPort busPort_i (
    .clk, .rst_n, .reqTag, .reqIndex, .victimTag, .victimLine, .wbStart, .rdStart,
    .refillEn, .rdReqReady_i, .rdDataValid_i, .rdData_i, .rdLast_i, .wrReqReady_i,
    .rdReqValid_o, .rdAddr_o, .wrReqValid_o, .wrAddr_o, .wrData_o, .refillLine,
    .rdDone, .wbDone
  );

endmodule

`default_nettype wire

// File: src/dcacheBusPort.sv
`timescale 1ns/10ps
`default_nettype none

module dcacheBusPort (
  input  wire                clk,
  input  wire                rst_n,
  input  dcachePkg::tagT     reqTag,
  input  dcachePkg::indexT   reqIndex,
  input  dcachePkg::tagT     victimTag,
  input  dcachePkg::lineT    victimLine,
  input  wire                wbStart,
  input  wire                rdStart,
  input  wire                refillEn,
  input  wire                rdReqReady_i,
  input  wire                rdDataValid_i,
  input  dcachePkg::wordT    rdData_i,
  input  wire                rdLast_i,
  input  wire                wrReqReady_i,
  output logic               rdReqValid_o,
  output dcachePkg::addrT    rdAddr_o,
  output logic               wrReqValid_o,
  output dcachePkg::addrT    wrAddr_o,
  output dcachePkg::lineT    wrData_o,
  output dcachePkg::lineT    refillLine,
  output logic               rdDone,
  output logic               wbDone
);

  dcachePkg::wordSelT beatCnt;
  logic               beatEn;

  assign beatEn = refillEn && rdDataValid_i;
  assign wbDone = wrReqValid_o && wrReqReady_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdReqValid_o <= 1'b0;
      wrReqValid_o <= 1'b0;
      beatCnt      <= '0;
      rdDone       <= 1'b0;
    end else begin
      if (rdStart) begin
        rdReqValid_o <= 1'b1;
      end else if (rdReqReady_i) begin
        rdReqValid_o <= 1'b0;
      end
      if (wbStart) begin
        wrReqValid_o <= 1'b1;
      end else if (wrReqReady_i) begin
        wrReqValid_o <= 1'b0;
      end
      // four beats wrap the counter back to zero
      if (beatEn) begin
        beatCnt <= beatCnt + 1'b1;
      end
      rdDone <= beatEn && rdLast_i;
    end
  end

  // line-aligned addresses, held until the handshake
  always_ff @(posedge clk) begin
    if (rdStart) begin
      rdAddr_o <= {reqTag, reqIndex, {dcachePkg::offsetWidth{1'b0}}};
    end
    if (wbStart) begin
      wrAddr_o <= {victimTag, reqIndex, {dcachePkg::offsetWidth{1'b0}}};
      wrData_o <= victimLine;
    end
    if (beatEn) begin
      refillLine[beatCnt*dcachePkg::xlen +: dcachePkg::xlen] <= rdData_i;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) rdLast_i |-> rdDataValid_i);

endmodule

`default_nettype wire

// File: src/dcacheDataStore.sv
`timescale 1ns/10ps
`default_nettype none

module dcacheDataStore (
  input  wire                  clk,
  input  wire                  rst_n,
  input  dcachePkg::indexT     reqIndex,
  input  dcachePkg::wordSelT   reqWordSel,
  input  dcachePkg::wordT      storeData,
  input  dcachePkg::wordT      storeBitMask,
  input  wire                  storeHit,
  input  wire                  hitWay,
  input  wire                  installEn,
  input  wire                  victimWay,
  input  dcachePkg::lineT      refillLine,
  output dcachePkg::wordT      respData_o,
  output dcachePkg::lineT      victimLine
);

  // two ways by sixteen lines
  dcachePkg::lineT  lineArr [2][dcachePkg::numSets];
  dcachePkg::lineT  hitLine;
  dcachePkg::wordT  oldWord;
  dcachePkg::wordT  mergedWord;

  assign hitLine    = lineArr[hitWay][reqIndex];
  assign victimLine = lineArr[victimWay][reqIndex];
  assign oldWord    = hitLine[reqWordSel*dcachePkg::xlen +: dcachePkg::xlen];
  assign respData_o = oldWord;

  // keep the bytes that the store does not enable
  assign mergedWord = (oldWord & ~storeBitMask) | (storeData & storeBitMask);

  always_ff @(posedge clk) begin
    if (installEn) begin
      lineArr[victimWay][reqIndex] <= refillLine;
    end else if (storeHit) begin
      lineArr[hitWay][reqIndex][reqWordSel*dcachePkg::xlen +: dcachePkg::xlen] <= mergedWord;
    end
  end

  // install only follows a refill, never a store hit in the same cycle
  assert property (@(posedge clk) disable iff (!rst_n)
    installEn |-> !storeHit ##1 !installEn);

endmodule

`default_nettype wire

// File: src/dcacheTagStore.sv
`timescale 1ns/10ps
`default_nettype none

module dcacheTagStore (
  input  wire                clk,
  input  wire                rst_n,
  input  dcachePkg::tagT     reqTag,
  input  dcachePkg::indexT   reqIndex,
  input  wire                lookupEn,
  input  wire                storeHit,
  input  wire                installEn,
  output logic               hit,
  output logic               hitWay,
  output logic               dirtyVictim,
  output logic               victimWay,
  output dcachePkg::tagT     victimTag
);

  logic [dcachePkg::numSets-1:0] validArr [2];
  logic [dcachePkg::numSets-1:0] dirtyArr [2];
  dcachePkg::tagT                tagArr   [2][dcachePkg::numSets];
  logic                          replPtr;
  logic                          hit0;
  logic                          hit1;

  assign hit0 = validArr[0][reqIndex] && (tagArr[0][reqIndex] == reqTag);
  assign hit1 = validArr[1][reqIndex] && (tagArr[1][reqIndex] == reqTag);

  assign hit         = lookupEn && (hit0 || hit1);
  assign hitWay      = hit1;
  assign victimWay   = replPtr;
  assign victimTag   = tagArr[replPtr][reqIndex];
  assign dirtyVictim = validArr[replPtr][reqIndex] && dirtyArr[replPtr][reqIndex];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr[0] <= '0;
      validArr[1] <= '0;
      dirtyArr[0] <= '0;
      dirtyArr[1] <= '0;
      replPtr     <= 1'b0;
    end else if (installEn) begin
      // fresh line from memory is clean
      validArr[replPtr][reqIndex] <= 1'b1;
      dirtyArr[replPtr][reqIndex] <= 1'b0;
      replPtr                     <= !replPtr;
    end else if (storeHit) begin
      dirtyArr[hitWay][reqIndex] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (installEn) begin
      tagArr[replPtr][reqIndex] <= reqTag;
    end
  end

  // a miss always installs into one way only, so no duplicate tags
  assert property (@(posedge clk) disable iff (!rst_n) lookupEn |-> !(hit0 && hit1));

endmodule

`default_nettype wire

// File: src/dcacheCtrl.sv
`timescale 1ns/10ps
`default_nettype none

module dcacheCtrl (
  input  wire   clk,
  input  wire   rst_n,
  input  wire   reqValid_i,
  input  wire   reqWrite,
  input  wire   hit,
  input  wire   dirtyVictim,
  input  wire   rdDone,
  input  wire   wbDone,
  output logic  reqReady_o,
  output logic  respValid_o,
  output logic  latchEn,
  output logic  lookupEn,
  output logic  storeHit,
  output logic  installEn,
  output logic  wbStart,
  output logic  rdStart,
  output logic  refillEn
);

  dcachePkg::cacheStateT state;
  dcachePkg::cacheStateT nextState;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= dcachePkg::IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      dcachePkg::IDLE: begin
        if (reqValid_i) begin
          nextState = dcachePkg::LOOKUP;
        end
      end
      dcachePkg::LOOKUP: begin
        if (hit) begin
          nextState = dcachePkg::IDLE;
        end else if (dirtyVictim) begin
          nextState = dcachePkg::WRITEBACK;
        end else begin
          nextState = dcachePkg::REFILLREQ;
        end
      end
      // victim line has to leave before the refill is asked for
      dcachePkg::WRITEBACK: begin
        if (wbDone) begin
          nextState = dcachePkg::REFILLREQ;
        end
      end
      dcachePkg::REFILLREQ: nextState = dcachePkg::REFILL;
      dcachePkg::REFILL: begin
        if (rdDone) begin
          nextState = dcachePkg::INSTALL;
        end
      end
      // lookup again so the response comes from the installed line
      dcachePkg::INSTALL: nextState = dcachePkg::LOOKUP;
      default: nextState = dcachePkg::IDLE;
    endcase
  end

  assign reqReady_o  = (state == dcachePkg::IDLE);
  assign latchEn     = reqReady_o && reqValid_i;
  assign lookupEn    = (state == dcachePkg::LOOKUP);
  assign respValid_o = lookupEn && hit;
  assign storeHit    = respValid_o && reqWrite;
  assign installEn   = (state == dcachePkg::INSTALL);
  assign refillEn    = (state == dcachePkg::REFILL);

  // start pulses on the edge into the bus states
  assign wbStart = lookupEn && !hit && dirtyVictim;
  assign rdStart = (lookupEn && !hit && !dirtyVictim)
                 || ((state == dcachePkg::WRITEBACK) && wbDone);

  // bus completions only arrive in the state that waits for them
  assert property (@(posedge clk) disable iff (!rst_n)
    rdDone |-> (state == dcachePkg::REFILL));
  assert property (@(posedge clk) disable iff (!rst_n)
    wbDone |-> (state == dcachePkg::WRITEBACK));

endmodule

`default_nettype wire

// File: src/dcacheReqPort.sv
`timescale 1ns/10ps
`default_nettype none

module dcacheReqPort (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        latchEn,
  input  wire                        lookupEn,
  input  wire                        reqWrite_i,
  input  dcachePkg::addrT            reqAddr_i,
  input  dcachePkg::wordT            reqWrData_i,
  input  dcachePkg::byteMaskT        reqWrMask_i,
  output logic                       reqWrite,
  output dcachePkg::tagT             reqTag,
  output dcachePkg::indexT           reqIndex,
  output dcachePkg::wordSelT         reqWordSel,
  output dcachePkg::wordT            storeData,
  output dcachePkg::wordT            storeBitMask
);

  dcachePkg::addrT      reqAddr;
  dcachePkg::byteMaskT  byteMask;
  logic                 held;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqWrite <= 1'b0;
      held     <= 1'b0;
    end else if (latchEn) begin
      reqWrite <= reqWrite_i;
      held     <= 1'b1;
    end else if (lookupEn) begin
      held <= 1'b0;
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (latchEn) begin
      reqAddr   <= reqAddr_i;
      storeData <= reqWrData_i;
      byteMask  <= reqWrMask_i;
    end
  end

  // low address bits below the word are ignored
  assign reqTag     = reqAddr[dcachePkg::addrWidth-1 -: dcachePkg::tagWidth];
  assign reqIndex   = reqAddr[dcachePkg::offsetWidth +: dcachePkg::indexWidth];
  assign reqWordSel = reqAddr[dcachePkg::offsetWidth-1 -: $bits(dcachePkg::wordSelT)];

  // one byte enable per eight data bits
  always_comb begin
    for (int i = 0; i < $bits(dcachePkg::byteMaskT); i++) begin
      storeBitMask[i*8 +: 8] = {8{byteMask[i]}};
    end
  end

  // a new request must not overwrite one that never reached lookup
  assert property (@(posedge clk) disable iff (!rst_n) latchEn |-> !held);

endmodule

`default_nettype wire

// File: src/dcachePkg.sv
`default_nettype none

package dcachePkg;

  // cache geometry
  localparam int addrWidth   = 32;
  localparam int xlen        = 64;
  localparam int lineWords   = 4;
  localparam int lineWidth   = 256;
  localparam int numSets     = 16;
  localparam int offsetWidth = 5;
  localparam int indexWidth  = 4;
  localparam int tagWidth    = 23;

  typedef logic [addrWidth-1:0]          addrT;
  typedef logic [xlen-1:0]               wordT;
  typedef logic [lineWidth-1:0]          lineT;
  typedef logic [tagWidth-1:0]           tagT;
  typedef logic [indexWidth-1:0]         indexT;
  typedef logic [$clog2(lineWords)-1:0]  wordSelT;
  typedef logic [xlen/8-1:0]             byteMaskT;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILLREQ,
    REFILL,
    INSTALL
  } cacheStateT;

endpackage

`default_nettype wire
